// ==== flist.f ====
core_pkg.sv
core_decode.sv
core_regfile.sv
core_execute.sv
core_result.sv
core_sequencer.sv
core_top.sv
tb_core.sv

// ==== Makefile ====
SIM   ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal
TOP   ?= tb_core
FLIST ?= flist.f
OBJ   := obj_dir
BIN   := $(OBJ)/V$(TOP)
LOG   := sim.log
SRCS  := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@! grep -q "\*\*\* FAILED \*\*\*" $(LOG)
	@grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// ==== tb_core.sv ====
// RV32I core testbench
// Memory model with random ack delays, generated program and store checks
`timescale 1ns/100ps

module tb_core;
    import core_pkg::*;

    localparam int TIMEOUT = 3000;

    logic clk = 1'b0;
    logic rstn;
    logic mem_req, mem_we, mem_ack, halt;
    word_t mem_addr, mem_wdata, mem_rdata;
    strb_t mem_wstrb;

    word_t mem [0:1023];
    word_t lfsr;
    word_t exp_addr [0:31];
    word_t exp_data [0:31];
    strb_t exp_strb [0:31];
    int n_exp, st_idx, errors, err_mark, n_tests, n_failed, dly, pc_b;

    core_top #(.RESET_PC(32'h0)) uut (
        .clk(clk), .rstn(rstn), .mem_req(mem_req), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_rdata(mem_rdata), .mem_ack(mem_ack), .halt(halt)
    );

    always #10 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic word_t rnd(input int nbits);
        word_t v;
        v = '0;
        for (int k = 0; k < nbits; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic word_t sext12(input word_t v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    // ########################################
    // Instruction encoders
    // ########################################
    function automatic word_t enc_i(input int imm, input int rs1, input int f3,
                                    input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t enc_r(input int f7, input int rs2, input int rs1,
                                    input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t enc_s(input int imm, input int rs2, input int rs1, input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(input int imm, input int rs2, input int rs1, input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic word_t enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input word_t w);
        mem[pc_b[11:2]] = w;
        pc_b = pc_b + 4;
    endtask

    task automatic add_store(input word_t a, input word_t d, input strb_t s);
        exp_addr[n_exp] = a;
        exp_data[n_exp] = d;
        exp_strb[n_exp] = s;
        n_exp++;
    endtask

    // ########################################
    // Memory model, four-phase slave
    // ########################################
    always @(negedge clk) begin
        if (!rstn) begin
            mem_ack = 1'b0;
            dly = 0;
        end else if (mem_req != mem_ack) begin
            if (dly > 0) begin
                dly--;
            end else if (mem_req) begin
                if (mem_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_wstrb[b]) mem[mem_addr[11:2]][8*b +: 8] = mem_wdata[8*b +: 8];
                    end
                end
                mem_rdata = mem[mem_addr[11:2]];
                mem_ack = 1'b1;
                dly = int'(rnd(2));
            end else begin
                mem_ack = 1'b0;
                dly = int'(rnd(2));
            end
        end
    end

    // Store order follows the table index
    always @(posedge clk) begin
        if (!rstn) begin
            st_idx <= 0;
        end else if (mem_req && mem_ack && mem_we) begin
            st_idx <= st_idx + 1;
        end
    end

    a_req_rise: assert property (@(posedge clk) disable iff (!rstn)
        $rose(mem_req) |-> !$past(mem_ack))
        else begin
            errors++;
            $display("ERROR at %0t: mem_req rose with mem_ack high", $time);
        end

    a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_req |=> !mem_req || ($stable(mem_addr) && $stable(mem_we) &&
                                 $stable(mem_wdata) && $stable(mem_wstrb)))
        else begin
            errors++;
            $display("ERROR at %0t: request fields changed", $time);
        end

    a_store: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && mem_ack && mem_we) |-> (st_idx < n_exp && mem_addr == exp_addr[st_idx] &&
            mem_wdata == exp_data[st_idx] && mem_wstrb == exp_strb[st_idx]))
        else begin
            errors++;
            $display("ERROR at %0t: store %0d addr %h data %h strb %b", $time, st_idx,
                     mem_addr, mem_wdata, mem_wstrb);
        end

    a_halt_quiet: assert property (@(posedge clk) disable iff (!rstn)
        halt |=> halt && !mem_req)
        else begin
            errors++;
            $display("ERROR at %0t: halt dropped or request after halt", $time);
        end

    // ########################################
    // Program image and expected stores
    // ########################################
    int alu_end, mem_end, ctrl_end;

    task automatic build_program();
        word_t va, vb, w, ub, ic, sh, ob, oub, oh, ouh;
        int jpc, apc;
        pc_b = 0;
        emit(enc_i(32'h400, 0, 0, 1, 7'h13));
        va = sext12(rnd(12));
        emit(enc_i(va, 0, 0, 2, 7'h13));
        ub = rnd(20);
        emit({ub[19:0], 5'd3, 7'b0110111});
        ic = rnd(12);
        emit(enc_i(ic, 3, 0, 3, 7'h13));
        vb = {ub[19:0], 12'b0} + sext12(ic);
        sh = rnd(5);
        emit(enc_i(sh, 0, 0, 9, 7'h13));
        emit(enc_s(0, 2, 1, 2));
        add_store(32'h400, va, 4'hF);
        emit(enc_s(4, 3, 1, 2));
        add_store(32'h404, vb, 4'hF);
        emit(enc_r(0, 3, 2, 0, 4));
        emit(enc_s(8, 4, 1, 2));
        add_store(32'h408, va + vb, 4'hF);
        emit(enc_r(7'h20, 3, 2, 0, 5));
        emit(enc_s(12, 5, 1, 2));
        add_store(32'h40C, va - vb, 4'hF);
        emit(enc_r(0, 3, 2, 4, 6));
        emit(enc_s(16, 6, 1, 2));
        add_store(32'h410, va ^ vb, 4'hF);
        emit(enc_r(0, 3, 2, 2, 7));
        emit(enc_s(20, 7, 1, 2));
        add_store(32'h414, ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0, 4'hF);
        emit(enc_r(7'h20, 9, 3, 5, 8));
        emit(enc_s(24, 8, 1, 2));
        // Sign bit copied into the upper half, then a plain right shift
        add_store(32'h418, word_t'({{32{vb[31]}}, vb} >> sh[4:0]), 4'hF);
        alu_end = n_exp;
        // Byte and halfword stores at every lane
        for (int k = 0; k < 4; k++) begin
            emit(enc_s(64 + k, 3, 1, 0));
            add_store(32'h440 + k, {4{vb[7:0]}}, strb_t'(4'b0001 << k));
        end
        for (int k = 0; k < 4; k += 2) begin
            emit(enc_s(72 + k, 3, 1, 1));
            add_store(32'h448 + k, {2{vb[15:0]}}, strb_t'(4'b0011 << k));
        end
        // Loads from a data word with every byte's top bit set
        w = rnd(32) | 32'h8080_8080;
        mem[32'h480 >> 2] = w;
        ob = rnd(2);
        oub = rnd(2);
        oh = rnd(1) << 1;
        ouh = rnd(1) << 1;
        emit(enc_i(32'h480, 0, 0, 14, 7'h13));
        emit(enc_i(ob, 14, 0, 15, 7'h03));
        emit(enc_s(80, 15, 1, 2));
        add_store(32'h450, {{24{w[8*ob+7]}}, w[8*ob +: 8]}, 4'hF);
        emit(enc_i(oub, 14, 4, 15, 7'h03));
        emit(enc_s(84, 15, 1, 2));
        add_store(32'h454, {24'b0, w[8*oub +: 8]}, 4'hF);
        emit(enc_i(oh, 14, 1, 15, 7'h03));
        emit(enc_s(88, 15, 1, 2));
        add_store(32'h458, {{16{w[8*oh+15]}}, w[8*oh +: 16]}, 4'hF);
        emit(enc_i(ouh, 14, 5, 15, 7'h03));
        emit(enc_s(92, 15, 1, 2));
        add_store(32'h45C, {16'b0, w[8*ouh +: 16]}, 4'hF);
        mem_end = n_exp;
        // Taken BEQ skips a stray store, not-taken BNE falls through
        emit(enc_b(8, 2, 2, 0));
        emit(enc_s(32'h7F0, 0, 0, 2));
        emit(enc_b(8, 2, 2, 1));
        emit(enc_s(96, 2, 1, 2));
        add_store(32'h460, va, 4'hF);
        jpc = pc_b;
        emit(enc_j(8, 11));
        emit(enc_s(32'h7F0, 0, 0, 2));
        emit(enc_s(100, 11, 1, 2));
        add_store(32'h464, jpc + 4, 4'hF);
        apc = pc_b;
        emit({20'h0, 5'd12, 7'b0010111});
        emit(enc_i(16, 12, 0, 13, 7'h67));
        emit(enc_s(32'h7F0, 0, 0, 2));
        emit(enc_s(32'h7F4, 0, 0, 2));
        emit(enc_s(104, 13, 1, 2));
        add_store(32'h468, apc + 8, 4'hF);
        emit(enc_s(108, 12, 1, 2));
        add_store(32'h46C, apc, 4'hF);
        ctrl_end = n_exp;
        emit(32'h0000_0073);
    endtask

    task automatic report_timeout(input string why);
        errors++;
        $display("Timeout: %s", why);
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (errors != err_mark) n_failed++;
        $display("test %s: %s", name, (errors == err_mark) ? "ok" : "failed");
        err_mark = errors;
    endtask

    task automatic wait_stores(input int target, input string name, output bit ok);
        int t;
        for (t = 0; t < TIMEOUT && st_idx < target; t++) @(negedge clk);
        ok = (st_idx >= target);
        if (!ok) begin
            report_timeout({"stores of test ", name, " never arrived"});
        end
        end_test(name);
    endtask

    // ########################################
    // Main sequence
    // ########################################
    initial begin
        int t;
        bit ok;
        rstn = 1'b0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        lfsr = 32'd75319;
        {n_exp, errors, err_mark, n_tests, n_failed, dly} = '0;
        for (int i = 0; i < 1024; i++) mem[i] = {~i[15:0], i[15:0]};
        build_program();
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        assert (!mem_req && !halt)
            else begin
                errors++;
                $display("ERROR at %0t: mem_req or halt set after reset", $time);
            end
        for (t = 0; t < 20 && !mem_req; t++) @(negedge clk);
        ok = mem_req;
        if (!ok) begin
            report_timeout("no fetch request after reset");
        end else begin
            assert (mem_addr == 32'h0)
                else begin
                    errors++;
                    $display("ERROR at %0t: first fetch at %h", $time, mem_addr);
                end
        end
        end_test("reset");
        if (ok) wait_stores(alu_end, "alu", ok);
        if (ok) wait_stores(mem_end, "load_store", ok);
        if (ok) wait_stores(ctrl_end, "control_flow", ok);
        if (ok) begin
            for (t = 0; t < TIMEOUT && !halt; t++) @(negedge clk);
            if (!halt) begin
                report_timeout("halt never rose after ECALL");
            end else begin
                // Quiet period, checked by the halt assertion
                repeat (50) @(negedge clk);
                assert (st_idx == n_exp)
                    else begin
                        errors++;
                        $display("ERROR at %0t: %0d stores seen", $time, st_idx);
                    end
            end
            end_test("halt");
        end
        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== core_top.sv ====
// RV32I single-issue core top level
// Sequencer, decode, register file, execute and result stages
`timescale 1ns/100ps

module core_top import core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rstn,
    output logic  mem_req,
    output logic  mem_we,
    output word_t mem_addr,
    output word_t mem_wdata,
    output strb_t mem_wstrb,
    input  word_t mem_rdata,
    input  logic  mem_ack,
    output logic  halt
);

    word_t      ir, pc, load_word;
    word_t      imm, rs1_data, rs2_data;
    word_t      exe_value, next_pc, wb_data, store_data;
    strb_t      store_strb;
    reg_idx_t   rs1, rs2, rd;
    alu_op_e    alu_op;
    logic [2:0] funct3;
    logic       use_imm, is_load, is_store, is_branch;
    logic       is_jal, is_jalr, is_lui, is_auipc;
    logic       is_system, reg_write, wb_en;

    core_sequencer #(.RESET_PC(RESET_PC)) u_seq (
        .clk(clk), .rstn(rstn), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .next_pc(next_pc), .exe_value(exe_value),
        .store_data(store_data), .store_strb(store_strb),
        .is_load(is_load), .is_store(is_store), .is_system(is_system),
        .reg_write(reg_write), .mem_req(mem_req), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .ir(ir), .pc(pc), .load_word(load_word), .wb_en(wb_en), .halt(halt)
    );

    core_decode u_dec (
        .ir(ir), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
        .funct3(funct3), .use_imm(use_imm), .is_load(is_load),
        .is_store(is_store), .is_branch(is_branch), .is_jal(is_jal),
        .is_jalr(is_jalr), .is_lui(is_lui), .is_auipc(is_auipc),
        .is_system(is_system), .reg_write(reg_write)
    );

    core_regfile u_rf (
        .clk(clk), .rstn(rstn), .rs1(rs1), .rs2(rs2), .rd(rd),
        .wb_en(wb_en), .wb_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    core_execute u_exe (
        .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .alu_op(alu_op), .use_imm(use_imm), .is_branch(is_branch),
        .is_jal(is_jal), .is_jalr(is_jalr), .is_lui(is_lui),
        .is_auipc(is_auipc), .exe_value(exe_value), .next_pc(next_pc)
    );

    core_result u_res (
        .exe_value(exe_value), .rs2_data(rs2_data), .funct3(funct3),
        .load_word(load_word), .is_load(is_load),
        .store_data(store_data), .store_strb(store_strb), .wb_data(wb_data)
    );

endmodule

// ==== core_sequencer.sv ====
// RV32I instruction sequencer
// Program counter, instruction register and the per-instruction FSM,
// driving fetch and data accesses over one four-phase memory port
`timescale 1ns/100ps

module core_sequencer import core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  mem_ack,
    input  word_t mem_rdata,
    input  word_t next_pc,
    input  word_t exe_value,
    input  word_t store_data,
    input  strb_t store_strb,
    input  logic  is_load,
    input  logic  is_store,
    input  logic  is_system,
    input  logic  reg_write,
    output logic  mem_req,
    output logic  mem_we,
    output word_t mem_addr,
    output word_t mem_wdata,
    output strb_t mem_wstrb,
    output word_t ir,
    output word_t pc,
    output word_t load_word,
    output logic  wb_en,
    output logic  halt
);

    typedef enum logic [2:0] {S_FETCH, S_EXEC, S_MEM, S_WB, S_HALT} state_e;

    state_e state;
    word_t  dat_addr;
    logic   idle_bus;
    logic   ack_now;

    // A new request needs both sides of the last handshake low
    assign idle_bus = !mem_req && !mem_ack;
    assign ack_now  = mem_req && mem_ack;

    // ######################################
    // FSM
    // ######################################
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= S_FETCH;
            pc      <= RESET_PC;
            ir      <= NOP_WORD;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (idle_bus) begin
                        mem_req <= 1'b1;
                    end else if (ack_now) begin
                        ir      <= mem_rdata;
                        mem_req <= 1'b0;
                        state   <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (is_system) begin
                        state <= S_HALT;
                    end else if (is_load || is_store) begin
                        mem_we <= is_store;
                        state  <= S_MEM;
                    end else begin
                        state <= S_WB;
                    end
                end
                S_MEM: begin
                    if (idle_bus) begin
                        mem_req <= 1'b1;
                    end else if (ack_now) begin
                        mem_req <= 1'b0;
                        mem_we  <= 1'b0;
                        state   <= S_WB;
                    end
                end
                S_WB: begin
                    pc    <= next_pc;
                    state <= S_FETCH;
                end
                // Halted until reset
                default: state <= S_HALT;
            endcase
        end
    end

    // Data access address and payload, plus captured read data
    always_ff @(posedge clk) begin
        if (state == S_EXEC) begin
            dat_addr  <= exe_value;
            mem_wdata <= store_data;
            mem_wstrb <= is_store ? store_strb : '0;
        end
        if (state == S_MEM && ack_now) begin
            load_word <= mem_rdata;
        end
    end

    // Fetch uses pc, which holds until write-back
    assign mem_addr = (state == S_MEM) ? dat_addr : pc;
    assign wb_en    = (state == S_WB) && reg_write;
    assign halt     = (state == S_HALT) || (state == S_EXEC && is_system);

    // ######################################
    // Checks
    // ######################################
    a_req_after_ack_low: assert property (@(posedge clk) disable iff (!rstn)
        $rose(mem_req) |-> !$past(mem_ack));

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rstn)
        halt |=> halt);

endmodule

// ==== core_result.sv ====
// RV32I load/store lane handling
// Store data replication and strobes, load extraction, write-back select
`timescale 1ns/100ps

module core_result import core_pkg::*; (
    input  word_t      exe_value,
    input  word_t      rs2_data,
    input  logic [2:0] funct3,
    input  word_t      load_word,
    input  logic       is_load,
    output word_t      store_data,
    output strb_t      store_strb,
    output word_t      wb_data
);

    logic [1:0] lane;
    word_t      shifted;
    word_t      load_val;

    // Byte offset of the access within the word
    assign lane = exe_value[1:0];

    // ######################################
    // Store formatting
    // ######################################
    always_comb begin
        case (funct3)
            F3_BYTE: begin
                store_data = {4{rs2_data[7:0]}};
                store_strb = strb_t'(4'b0001 << lane);
            end
            F3_HALF: begin
                store_data = {2{rs2_data[15:0]}};
                store_strb = strb_t'(4'b0011 << lane);
            end
            default: begin
                // Full word
                store_data = rs2_data;
                store_strb = 4'b1111;
            end
        endcase
    end

    // ######################################
    // Load extraction
    // ######################################
    // Addressed byte or halfword moved down to bit 0
    assign shifted = load_word >> {lane, 3'b000};

    always_comb begin
        case (funct3)
            F3_BYTE:   load_val = {{24{shifted[7]}}, shifted[7:0]};
            F3_HALF:   load_val = {{16{shifted[15]}}, shifted[15:0]};
            F3_BYTE_U: load_val = {24'b0, shifted[7:0]};
            F3_HALF_U: load_val = {16'b0, shifted[15:0]};
            F3_WORD:   load_val = load_word;
            default:   load_val = load_word;
        endcase
    end

    assign wb_data = is_load ? load_val : exe_value;

endmodule

// ==== core_execute.sv ====
// RV32I execute stage
// ALU with branch compare, write-back value for jumps and upper immediates,
// next program counter
`timescale 1ns/100ps

module core_execute import core_pkg::*; (
    input  word_t   pc,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    input  word_t   imm,
    input  alu_op_e alu_op,
    input  logic    use_imm,
    input  logic    is_branch,
    input  logic    is_jal,
    input  logic    is_jalr,
    input  logic    is_lui,
    input  logic    is_auipc,
    output word_t   exe_value,
    output word_t   next_pc
);

    word_t op_b;
    word_t alu_res;
    word_t pc_plus4;
    word_t pc_target;
    logic  taken;

    assign op_b = use_imm ? imm : rs2_data;

    // ######################################
    // ALU
    // ######################################
    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_res = rs1_data + op_b;
            ALU_SUB:  alu_res = rs1_data - op_b;
            ALU_SLL:  alu_res = rs1_data << op_b[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(rs1_data) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, rs1_data < op_b};
            ALU_XOR:  alu_res = rs1_data ^ op_b;
            ALU_SRL:  alu_res = rs1_data >> op_b[4:0];
            ALU_SRA:  alu_res = word_t'($signed(rs1_data) >>> op_b[4:0]);
            ALU_OR:   alu_res = rs1_data | op_b;
            ALU_AND:  alu_res = rs1_data & op_b;
            // Branch compares leave the outcome in bit 0
            ALU_EQ:   alu_res = {31'b0, rs1_data == op_b};
            ALU_NE:   alu_res = {31'b0, rs1_data != op_b};
            ALU_LT:   alu_res = {31'b0, $signed(rs1_data) < $signed(op_b)};
            ALU_GE:   alu_res = {31'b0, $signed(rs1_data) >= $signed(op_b)};
            ALU_LTU:  alu_res = {31'b0, rs1_data < op_b};
            ALU_GEU:  alu_res = {31'b0, rs1_data >= op_b};
            default:  alu_res = rs1_data + op_b;
        endcase
    end

    // ######################################
    // Result and next pc
    // ######################################
    assign pc_plus4  = pc + 32'd4;
    // Branch and JAL target, also the AUIPC result
    assign pc_target = pc + imm;
    assign taken     = is_branch && alu_res[0];

    // Link value for jumps, effective address for loads and stores
    assign exe_value = is_lui              ? imm :
                       is_auipc            ? pc_target :
                       (is_jal || is_jalr) ? pc_plus4 :
                       alu_res;

    // JALR target is rs1 + imm with bit 0 cleared
    assign next_pc = is_jalr             ? {alu_res[31:1], 1'b0} :
                     (is_jal || taken)   ? pc_target :
                     pc_plus4;

endmodule

// ==== core_regfile.sv ====
// RV32I register file
// 32 x 32 bits, two combinational reads, one write, x0 reads as zero
`timescale 1ns/100ps

module core_regfile import core_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     wb_en,
    input  word_t    wb_data,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    // No storage behind x0
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (rd != 5'd0)) begin
            regs[rd] <= wb_data;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

    // Decode already filters x0 out of reg_write
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rstn)
        wb_en |-> (rd != 5'd0));

endmodule

// ==== core_decode.sv ====
// RV32I instruction decoder
// Splits the instruction into fields, picks the immediate and flags the class
`timescale 1ns/100ps

module core_decode import core_pkg::*; (
    input  word_t    ir,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm,
    output alu_op_e  alu_op,
    output logic [2:0] funct3,
    output logic     use_imm,
    output logic     is_load,
    output logic     is_store,
    output logic     is_branch,
    output logic     is_jal,
    output logic     is_jalr,
    output logic     is_lui,
    output logic     is_auipc,
    output logic     is_system,
    output logic     reg_write
);

    opcode_e    opcode;
    logic [6:0] funct7;
    logic       is_rtype;
    logic       is_itype;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // ######################################
    // Fields
    // ######################################
    assign opcode = opcode_e'(ir[6:0]);
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign funct7 = ir[31:25];

    // Class flags, unknown opcodes decode as a no-op
    assign is_rtype  = (opcode == OP_R);
    assign is_itype  = (opcode == OP_IMM);
    assign is_load   = (opcode == OP_LOAD);
    assign is_store  = (opcode == OP_STORE);
    assign is_branch = (opcode == OP_BRANCH);
    assign is_jal    = (opcode == OP_JAL);
    assign is_jalr   = (opcode == OP_JALR);
    assign is_lui    = (opcode == OP_LUI);
    assign is_auipc  = (opcode == OP_AUIPC);
    // ECALL and EBREAK, both with funct3 zero
    assign is_system = (opcode == OP_SYSTEM) && (funct3 == 3'b000);

    // Second ALU operand from the immediate
    assign use_imm = is_itype | is_load | is_store | is_jalr;

    // Writes to x0 are dropped here
    assign reg_write = (is_rtype | is_itype | is_load | is_jal | is_jalr |
                        is_lui | is_auipc) && (rd != 5'd0);

    // ######################################
    // Immediates
    // ######################################
    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    always_comb begin
        if (is_store) begin
            imm = imm_s;
        end else if (is_branch) begin
            imm = imm_b;
        end else if (is_jal) begin
            imm = imm_j;
        end else if (is_lui || is_auipc) begin
            imm = imm_u;
        end else begin
            // I-type ALU, loads and JALR
            imm = imm_i;
        end
    end

    // ######################################
    // ALU operation
    // ######################################
    always_comb begin
        // Address adds for loads, stores and JALR
        alu_op = ALU_ADD;
        if (is_branch) begin
            case (funct3)
                3'b001:  alu_op = ALU_NE;
                3'b100:  alu_op = ALU_LT;
                3'b101:  alu_op = ALU_GE;
                3'b110:  alu_op = ALU_LTU;
                3'b111:  alu_op = ALU_GEU;
                default: alu_op = ALU_EQ;
            endcase
        end else if (is_rtype || is_itype) begin
            case (funct3)
                // SUB only exists in R-type
                3'b000: alu_op = (is_rtype && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: alu_op = ALU_OR;
                3'b111: alu_op = ALU_AND;
            endcase
        end
    end

endmodule

// ==== core_pkg.sv ====
// RV32I core shared definitions
// Word and index types, opcode and ALU encodings, load/store size codes
package core_pkg;

    // Data, address and instruction word
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    // One enable bit per byte lane
    typedef logic [3:0]  strb_t;

    // Major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // ALU operations, the last six are the branch compares
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
        ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
        ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } alu_op_e;

    // Load/store size codes in funct3
    localparam logic [2:0] F3_BYTE   = 3'b000;
    localparam logic [2:0] F3_HALF   = 3'b001;
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_BYTE_U = 3'b100;
    localparam logic [2:0] F3_HALF_U = 3'b101;

    // addi x0, x0, 0
    localparam word_t NOP_WORD = 32'h0000_0013;

endpackage
